// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_chip_top
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: rtl/chip_pkg.sv
/*
  Chip-wide definitions
  Widths, typedefs and structs shared by the configuration
  blocks and the link tunnel, plus the tag master FSM states
*/
package chip_pkg;

  // Configuration stream
  localparam int TAG_ID_W      = 2;
  localparam int TAG_PAYLOAD_W = 16;

  // Link channel and flit sizes
  localparam int CORD_W         = 7;
  localparam int BEAT_W         = 8;
  localparam int FLIT_W         = 32;
  localparam int BEATS_PER_FLIT = FLIT_W / BEAT_W;

  typedef logic [TAG_PAYLOAD_W-1:0] tag_payload_t;
  typedef logic [TAG_ID_W-1:0]      tag_id_t;
  typedef logic [CORD_W-1:0]        cord_t;
  typedef logic [BEAT_W-1:0]        beat_t;
  typedef logic [FLIT_W-1:0]        flit_t;

  // One addressed configuration write
  typedef struct packed {
    tag_id_t      id;
    tag_payload_t data;
  } tag_write_s;

  // Rebuilt flit with the node coordinate stamped on
  typedef struct packed {
    cord_t src;
    flit_t data;
  } link_out_s;

  typedef enum logic [1:0] {TAG_IDLE, TAG_ID, TAG_DATA} tag_state_e;

endpackage

// File: rtl/chip_top.sv
/*
  Chip top level
  Tag master with link-reset and cord clients, and a flit link
  looped back through sender, receive FIFO and consumer
*/
`timescale 1ns/1ps

module chip_top
  import chip_pkg::*;
 #(parameter int LG_FIFO_DEPTH = 3)
 (input  logic      clk_i
 ,input  logic      rst_i
 ,input  logic      tag_en_i
 ,input  logic      tag_data_i
 ,input  logic      in_v_i
 ,input  flit_t     in_data_i
 ,output logic      in_ready_o
 ,output logic      out_v_o
 ,output link_out_s out_data_o
 ,input  logic      out_ready_i
 );

  ////////////////////////////////////////
  // Configuration

  logic       write_v;
  tag_write_s write;
  logic [0:0] link_reset_lo;
  cord_t      cord_lo;
  logic       link_reset;

  tag_master tag_master_inst
    (.clk_i(clk_i), .rst_i(rst_i), .tag_en_i(tag_en_i), .tag_data_i(tag_data_i)
    ,.write_v_o(write_v), .write_o(write)
    );

  // Link held in reset until configured
  tag_client #(.CLIENT_ID(tag_id_t'(0)), .PAYLOAD_W(1), .RESET_VAL(1'b1)) reset_client
    (.clk_i(clk_i), .rst_i(rst_i), .write_v_i(write_v), .write_i(write)
    ,.data_o(link_reset_lo), .new_o()
    );

  tag_client #(.CLIENT_ID(tag_id_t'(1)), .PAYLOAD_W(CORD_W), .RESET_VAL('0)) cord_client
    (.clk_i(clk_i), .rst_i(rst_i), .write_v_i(write_v), .write_i(write)
    ,.data_o(cord_lo), .new_o()
    );

  assign link_reset = rst_i | link_reset_lo[0];

  ////////////////////////////////////////
  // Link loopback

  logic  beat_v;
  beat_t beat;
  logic  token;
  logic  deq_v;
  beat_t deq;
  logic  deq_ready;

  link_upstream #(.LG_FIFO_DEPTH(LG_FIFO_DEPTH)) upstream
    (.clk_i(clk_i), .rst_i(link_reset), .in_v_i(in_v_i), .in_data_i(in_data_i)
    ,.in_ready_o(in_ready_o), .beat_v_o(beat_v), .beat_o(beat), .token_i(token)
    );

  link_fifo #(.LG_FIFO_DEPTH(LG_FIFO_DEPTH)) rx_fifo
    (.clk_i(clk_i), .rst_i(link_reset), .beat_v_i(beat_v), .beat_i(beat)
    ,.deq_v_o(deq_v), .deq_o(deq), .deq_ready_i(deq_ready), .token_o(token)
    );

  link_downstream downstream
    (.clk_i(clk_i), .rst_i(link_reset), .deq_v_i(deq_v), .deq_i(deq)
    ,.deq_ready_o(deq_ready), .cord_i(cord_lo), .out_v_o(out_v_o)
    ,.out_o(out_data_o), .out_ready_i(out_ready_i)
    );

endmodule

// File: rtl/link_downstream.sv
/*
  Link downstream consumer
  Rebuilds flits from dequeued beats and stamps each one with
  the configured cord in an output holding register
*/
`timescale 1ns/1ps

module link_downstream
  import chip_pkg::*;
 (input  logic      clk_i
 ,input  logic      rst_i
 ,input  logic      deq_v_i
 ,input  beat_t     deq_i
 ,output logic      deq_ready_o
 ,input  cord_t     cord_i
 ,output logic      out_v_o
 ,output link_out_s out_o
 ,input  logic      out_ready_i
 );

  localparam int CNT_W = $clog2(BEATS_PER_FLIT);

  logic [CNT_W-1:0] cnt_r;
  flit_t            asm_r;
  flit_t            asm_next;
  link_out_s        out_r;
  logic             out_v_r;
  logic             deq;
  logic             last;

  // Take beats only when the holding register can drain
  assign deq_ready_o = ~out_v_r | out_ready_i;
  assign deq         = deq_v_i & deq_ready_o;
  assign last        = (cnt_r == CNT_W'(BEATS_PER_FLIT - 1));
  // Beats arrive LSB first, new one enters at the top
  assign asm_next    = {deq_i, asm_r[FLIT_W-1:BEAT_W]};

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cnt_r   <= '0;
      out_v_r <= 1'b0;
    end
    else
    begin
      if (deq)
        cnt_r <= cnt_r + 1'b1;
      if (deq && last)
        out_v_r <= 1'b1;
      else if (out_ready_i)
        out_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (deq)
      asm_r <= asm_next;
    if (deq && last)
    begin
      out_r.data <= asm_next;
      out_r.src  <= cord_i;
    end
  end

  assign out_v_o = out_v_r;
  assign out_o   = out_r;

endmodule

// File: rtl/link_fifo.sv
/*
  Link receive FIFO
  Circular beat buffer on the far end of the channel. Sends one
  token back upstream for every beat it releases.
*/
`timescale 1ns/1ps

module link_fifo
  import chip_pkg::*;
 #(parameter int LG_FIFO_DEPTH = 3)
 (input  logic  clk_i
 ,input  logic  rst_i
 ,input  logic  beat_v_i
 ,input  beat_t beat_i
 ,output logic  deq_v_o
 ,output beat_t deq_o
 ,input  logic  deq_ready_i
 ,output logic  token_o
 );

  localparam int DEPTH = 2 ** LG_FIFO_DEPTH;

  beat_t                mem_r [DEPTH];
  // Top bit is the wrap flag
  logic [LG_FIFO_DEPTH:0] wptr_r;
  logic [LG_FIFO_DEPTH:0] rptr_r;
  logic                   token_r;
  logic                   empty;
  logic                   deq;

  assign empty   = (wptr_r == rptr_r);
  assign deq_v_o = ~empty;
  assign deq     = deq_v_o & deq_ready_i;
  assign deq_o   = mem_r[rptr_r[LG_FIFO_DEPTH-1:0]];
  assign token_o = token_r;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      token_r <= 1'b0;
    end
    else
    begin
      // Credits upstream guarantee room for every beat
      if (beat_v_i)
        wptr_r <= wptr_r + 1'b1;
      if (deq)
        rptr_r <= rptr_r + 1'b1;
      token_r <= deq;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (beat_v_i)
      mem_r[wptr_r[LG_FIFO_DEPTH-1:0]] <= beat_i;
  end

endmodule

// File: rtl/link_upstream.sv
/*
  Link upstream sender
  Holds one flit and sends it over the narrow channel as beats,
  least significant first, only while credits remain
*/
`timescale 1ns/1ps

module link_upstream
  import chip_pkg::*;
 #(parameter int LG_FIFO_DEPTH = 3)
 (input  logic  clk_i
 ,input  logic  rst_i
 ,input  logic  in_v_i
 ,input  flit_t in_data_i
 ,output logic  in_ready_o
 ,output logic  beat_v_o
 ,output beat_t beat_o
 ,input  logic  token_i
 );

  localparam int CNT_W    = $clog2(BEATS_PER_FLIT);
  localparam int CREDIT_W = LG_FIFO_DEPTH + 1;

  flit_t               flit_r;
  logic                busy_r;
  logic                live_r;
  logic [CNT_W-1:0]    cnt_r;
  logic [CREDIT_W-1:0] credits_r;
  logic                accept;
  logic                send;

  // Ready stays low for one cycle when leaving link reset
  assign in_ready_o = live_r & ~busy_r;
  assign accept     = in_v_i & in_ready_o;
  assign send       = busy_r & (credits_r != '0);
  assign beat_v_o   = send;
  assign beat_o     = beat_t'(flit_r);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      live_r    <= 1'b0;
      busy_r    <= 1'b0;
      cnt_r     <= '0;
      credits_r <= CREDIT_W'(2 ** LG_FIFO_DEPTH);
    end
    else
    begin
      live_r <= 1'b1;
      if (accept)
      begin
        busy_r <= 1'b1;
        cnt_r  <= '0;
      end
      else if (send)
      begin
        cnt_r <= cnt_r + 1'b1;
        if (cnt_r == CNT_W'(BEATS_PER_FLIT - 1))
          busy_r <= 1'b0;
      end
      // Beat out and token back in the same cycle cancel
      case ({send, token_i})
        2'b10:   credits_r <= credits_r - 1'b1;
        2'b01:   credits_r <= credits_r + 1'b1;
        default: credits_r <= credits_r;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      flit_r <= in_data_i;
    else if (send)
      flit_r <= flit_r >> BEAT_W;
  end

endmodule

// File: rtl/tag_client.sv
/*
  Tag client
  Configuration register that loads writes addressed to its own
  id and flags each update for one cycle
*/
`timescale 1ns/1ps

module tag_client
  import chip_pkg::*;
 #(parameter tag_id_t              CLIENT_ID = '0
  ,parameter int                   PAYLOAD_W = TAG_PAYLOAD_W
  ,parameter logic [PAYLOAD_W-1:0] RESET_VAL = '0
  )
 (input  logic                 clk_i
 ,input  logic                 rst_i
 ,input  logic                 write_v_i
 ,input  tag_write_s           write_i
 ,output logic [PAYLOAD_W-1:0] data_o
 ,output logic                 new_o
 );

  logic [PAYLOAD_W-1:0] data_r;
  logic                 new_r;
  logic                 hit;

  assign hit = write_v_i && (write_i.id == CLIENT_ID);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      data_r <= RESET_VAL;
      new_r  <= 1'b0;
    end
    else
    begin
      new_r <= hit;
      // only the low bits of the payload are kept
      if (hit)
        data_r <= write_i.data[PAYLOAD_W-1:0];
    end
  end

  assign data_o = data_r;
  assign new_o  = new_r;

endmodule

// File: rtl/tag_master.sv
/*
  Tag master
  Decodes the one-bit serial configuration stream into addressed
  payload writes. A frame is a start bit, the client id and the
  payload, both MSB first.
*/
`timescale 1ns/1ps

module tag_master
  import chip_pkg::*;
 (input  logic       clk_i
 ,input  logic       rst_i
 ,input  logic       tag_en_i
 ,input  logic       tag_data_i
 ,output logic       write_v_o
 ,output tag_write_s write_o
 );

  localparam int CNT_W = $clog2(TAG_PAYLOAD_W);

  tag_state_e       state_r;
  logic [CNT_W-1:0] cnt_r;
  logic             write_v_r;
  tag_id_t          id_r;
  tag_payload_t     data_r;

  ////////////////////////////////////////
  // Frame FSM

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r   <= TAG_IDLE;
      cnt_r     <= '0;
      write_v_r <= 1'b0;
    end
    else
    begin
      write_v_r <= 1'b0;
      // Bits outside the enable window are dropped
      if (tag_en_i)
      begin
        case (state_r)
          TAG_IDLE:
          begin
            cnt_r <= '0;
            if (tag_data_i)
              state_r <= TAG_ID;
          end
          TAG_ID:
          begin
            if (cnt_r == CNT_W'(TAG_ID_W - 1))
            begin
              cnt_r   <= '0;
              state_r <= TAG_DATA;
            end
            else
              cnt_r <= cnt_r + 1'b1;
          end
          TAG_DATA:
          begin
            cnt_r <= cnt_r + 1'b1;
            // Last payload bit, write goes out next cycle
            if (cnt_r == CNT_W'(TAG_PAYLOAD_W - 1))
            begin
              state_r   <= TAG_IDLE;
              write_v_r <= 1'b1;
            end
          end
          default: state_r <= TAG_IDLE;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Id and payload shifters

  always_ff @(posedge clk_i)
  begin
    if (tag_en_i && state_r == TAG_ID)
      id_r <= tag_id_t'({id_r, tag_data_i});
    if (tag_en_i && state_r == TAG_DATA)
      data_r <= tag_payload_t'({data_r, tag_data_i});
  end

  assign write_v_o    = write_v_r;
  assign write_o.id   = id_r;
  assign write_o.data = data_r;

endmodule

// File: sources.f
rtl/chip_pkg.sv
rtl/tag_master.sv
rtl/tag_client.sv
rtl/link_upstream.sv
rtl/link_fifo.sv
rtl/link_downstream.sv
rtl/chip_top.sv
testbench/tb_chip_top.sv

// File: testbench/chip_tests.txt
# N name | T id payload en | F first_flit count | R ready_percent (0 = back-pressure window)
# id, payload and flit in hex; en, count and percent in decimal
N link_enable
T 0 0000 1
R 100
N cord_stamp
T 1 0025 1
F deadbeef 2
N in_order
F 00000001 8
N back_pressure
R 0
F 0badf00d 8
N random_ready
R 30
F a5000000 5
T 1 0013 1
F 5a000000 5
T 1 0042 1
F c3000000 5
T 1 007f 1
F 3c000000 5
N ignored_frame
R 100
T 1 0055 0
F 12345678 2

// File: testbench/tb_chip_top.sv
/*
  Chip top testbench
  Reads tag frames, flits and ready settings from a test file,
  drives the configuration stream and the flit path, and checks
  every output flit and its cord against a scoreboard queue
*/
`timescale 1ns/1ps

module tb_chip_top
  import chip_pkg::*;
 ();

  localparam int WAIT_LIMIT = 2000;
  localparam int BP_CYCLES  = 200;

  logic      clk;
  logic      rst_i;
  logic      tag_en_i;
  logic      tag_data_i;
  logic      in_v_i;
  flit_t     in_data_i;
  logic      in_ready_o;
  logic      out_v_o;
  link_out_s out_data_o;
  logic      out_ready_i;

  int        value_errors = 0;
  int        other_errors = 0;
  int        ready_pct = 100;
  int        bp_left = 0;
  int        seed_ret;
  string     test_name = "reset_hold";
  cord_t     cord_model = '0;
  link_out_s expected_q [$];
  link_out_s head;

  chip_top #(.LG_FIFO_DEPTH(3)) DUT
    (.clk_i(clk), .rst_i(rst_i), .tag_en_i(tag_en_i), .tag_data_i(tag_data_i)
    ,.in_v_i(in_v_i), .in_data_i(in_data_i), .in_ready_o(in_ready_o)
    ,.out_v_o(out_v_o), .out_data_o(out_data_o), .out_ready_i(out_ready_i)
    );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Compare tasks

  task automatic compare_flit(input string name, input flit_t exp, input flit_t act);
    if (exp !== act)
    begin
      $display("FAILED %s: flit expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic compare_cord(input string name, input cord_t exp, input cord_t act);
    if (exp !== act)
    begin
      $display("FAILED %s: cord expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  ////////////////////////////////////////
  // Drivers

  // Scoreboard empty means every sent flit has come out
  task automatic wait_link_idle();
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (expected_q.size() != 0)
    begin
      $display("ERROR: link did not drain within %0d cycles in test %s", WAIT_LIMIT,
               test_name);
      other_errors++;
    end
  endtask

  task automatic send_tag(input tag_id_t id, input tag_payload_t payload, input logic en);
    logic [TAG_ID_W+TAG_PAYLOAD_W:0] frame;
    wait_link_idle();
    frame = {1'b1, id, payload};
    for (int i = TAG_ID_W + TAG_PAYLOAD_W; i >= 0; i--)
    begin
      @(negedge clk);
      tag_en_i   = en;
      tag_data_i = frame[i];
    end
    @(negedge clk);
    tag_en_i   = 1'b0;
    tag_data_i = 1'b0;
    // Write pulse, then client register update
    repeat (2) @(negedge clk);
    if (en && id == tag_id_t'(1))
      cord_model = cord_t'(payload);
  endtask

  task automatic send_flit(input flit_t flit);
    int        cycles;
    link_out_s entry;
    cycles    = 0;
    in_v_i    = 1'b1;
    in_data_i = flit;
    while (!in_ready_o && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!in_ready_o)
    begin
      $display("ERROR: flit %h not accepted within %0d cycles in test %s", flit,
               WAIT_LIMIT, test_name);
      other_errors++;
    end
    else
    begin
      @(posedge clk);
      entry.src  = cord_model;
      entry.data = flit;
      expected_q.push_back(entry);
    end
    @(negedge clk);
    in_v_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // Output ready and monitor

  initial
  begin
    seed_ret = $urandom(32'hffec2dd3);
    forever
    begin
      @(negedge clk);
      if (bp_left > 0)
      begin
        out_ready_i = 1'b0;
        bp_left--;
        // By now the sender must be stuck mid-flit
        if (bp_left == 0 && (in_ready_o || !out_v_o))
        begin
          $display("ERROR: sender did not stall under back-pressure in test %s",
                   test_name);
          other_errors++;
        end
      end
      else if (!rst_i)
        out_ready_i = ($urandom % 100) < ready_pct;
    end
  end

  always @(posedge clk)
  begin
    if (!rst_i && out_v_o && out_ready_i)
    begin
      if (expected_q.size() == 0)
      begin
        $display("ERROR: output flit %h with nothing outstanding in test %s",
                 out_data_o.data, test_name);
        other_errors++;
      end
      else
      begin
        head = expected_q.pop_front();
        compare_flit(test_name, head.data, out_data_o.data);
        compare_cord(test_name, head.src, out_data_o.src);
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence

  initial
  begin
    string       line;
    string       kind;
    int          fd;
    int          code;
    int          en;
    int          count;
    int          pct;
    logic [31:0] a;
    logic [31:0] b;
    rst_i       = 1'b1;
    tag_en_i    = 1'b0;
    tag_data_i  = 1'b0;
    in_v_i      = 1'b0;
    in_data_i   = '0;
    out_ready_i = 1'b0;
    repeat (16) @(negedge clk);
    rst_i = 1'b0;

    // Link reset client still set, nothing may move
    repeat (50)
    begin
      @(negedge clk);
      if (in_ready_o || out_v_o)
      begin
        $display("ERROR: link active while held in link reset");
        other_errors++;
      end
    end

    fd = $fopen("testbench/chip_tests.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR: cannot open test file testbench/chip_tests.txt");
      other_errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        code = $fgets(line, fd);
        if (code == 0 || line.len() < 2 || line[0] == "#")
          continue;
        code = $sscanf(line, "%s", kind);
        case (kind)
          "N": code = $sscanf(line, "%s %s", kind, test_name);
          "T":
          begin
            code = $sscanf(line, "%s %h %h %d", kind, a, b, en);
            send_tag(tag_id_t'(a), tag_payload_t'(b), en[0]);
          end
          "F":
          begin
            code = $sscanf(line, "%s %h %d", kind, a, count);
            for (int i = 0; i < count; i++)
            begin
              send_flit(a);
              a = a + 32'h01020304;
            end
          end
          "R":
          begin
            code = $sscanf(line, "%s %d", kind, pct);
            // Zero means a fixed back-pressure window
            if (pct == 0)
              bp_left = BP_CYCLES;
            else
              ready_pct = pct;
          end
          default:
          begin
            $display("ERROR: unknown line in test file: %s", line);
            other_errors++;
          end
        endcase
      end
      $fclose(fd);
    end

    wait_link_idle();
    $display("Error counts: %0d value mismatches, %0d other failures", value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
